// ==== verilog/rx_pkg.sv ====
// receive path package with shared widths, types and frame word layout
package rx_pkg;

    localparam int BYTE_W         = 8;
    localparam int WORD_W         = 64;
    localparam int BYTES_PER_WORD = WORD_W / BYTE_W;
    localparam int FIFO_DEPTH     = 32;
    localparam int PTR_W          = $clog2(FIFO_DEPTH);
    // header plus trailer around every frame
    localparam int FRAME_OVERHEAD = 2;

    typedef logic [BYTE_W-1:0]                 byte_t;
    typedef logic [WORD_W-1:0]                 word_t;
    typedef logic [15:0]                       len_t;
    typedef logic [7:0]                        rate_t;
    typedef logic [15:0]                       sn_t;
    typedef logic [PTR_W:0]                    cnt_t;
    typedef logic [PTR_W-1:0]                  ptr_t;
    typedef logic [$clog2(BYTES_PER_WORD)-1:0] byte_lane_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PAYLOAD,
        ST_TRAILER,
        ST_DISCARD
    } builder_state_t;

    // header word fields
    localparam int HDR_LEN_LSB  = 0;
    localparam int HDR_RATE_LSB = 16;
    localparam int HDR_SN_LSB   = 32;
    // trailer word fields
    localparam int TRL_FCS_BIT  = 0;
    localparam int TRL_CNT_LSB  = 16;

endpackage

// ==== verilog/rx_word_if.sv ====
// packed payload word link from the byte packer to the frame builder
`timescale 1ns/10ps

interface rx_word_if;
    rx_pkg::word_t word;
    logic          valid;
    logic          last;
    rx_pkg::len_t  byte_cnt;

    modport source (
        output word,
        output valid,
        output last,
        output byte_cnt
    );

    modport sink (
        input word,
        input valid,
        input last,
        input byte_cnt
    );
endinterface

// ==== verilog/rx_fifo_wr_if.sv ====
// frame word write link from the frame builder into the DMA FIFO
`timescale 1ns/10ps

interface rx_fifo_wr_if;
    rx_pkg::word_t wdata;
    logic          wlast;
    logic          wen;
    rx_pkg::cnt_t  free_cnt;

    modport source (
        output wdata,
        output wlast,
        output wen,
        input  free_cnt
    );

    modport sink (
        input  wdata,
        input  wlast,
        input  wen,
        output free_cnt
    );
endinterface

// ==== verilog/rx_byte_packer.sv ====
// byte packer, gathers decoded bytes into 64-bit payload words
`timescale 1ns/10ps

module rx_byte_packer (
    input  logic          clk,
    input  logic          rst_i,
    input  logic          hdr_strobe_i,
    input  rx_pkg::byte_t byte_in_i,
    input  logic          byte_in_strobe_i,
    input  logic          fcs_in_strobe_i,
    rx_word_if.source     word_o
);

    rx_pkg::word_t      acc_q;
    rx_pkg::word_t      word_q;
    rx_pkg::byte_lane_t lane_q;
    rx_pkg::len_t       cnt_q;
    logic               valid_q;
    logic               last_q;
    logic               lane_full;

    assign lane_full = (lane_q == rx_pkg::byte_lane_t'(rx_pkg::BYTES_PER_WORD - 1));

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            lane_q  <= '0;
            cnt_q   <= '0;
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end
        else
        begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
            if (hdr_strobe_i)
            begin
                lane_q <= '0;
                cnt_q  <= '0;
            end
            else if (byte_in_strobe_i)
            begin
                lane_q  <= lane_q + 1'b1;
                cnt_q   <= cnt_q + 1'b1;
                valid_q <= lane_full;
            end
            else if (fcs_in_strobe_i)
            begin
                // end beat, plus a flush when a partial word is pending
                lane_q  <= '0;
                last_q  <= 1'b1;
                valid_q <= (lane_q != '0);
            end
        end
    end

    // lanes are cleared after each word so a flushed word is zero padded
    always_ff @(posedge clk)
    begin
        if (hdr_strobe_i)
            acc_q <= '0;
        else if (byte_in_strobe_i)
        begin
            if (lane_full)
            begin
                word_q <= {byte_in_i, acc_q[rx_pkg::WORD_W-rx_pkg::BYTE_W-1:0]};
                acc_q  <= '0;
            end
            else
                acc_q[rx_pkg::BYTE_W*lane_q +: rx_pkg::BYTE_W] <= byte_in_i;
        end
        else if (fcs_in_strobe_i)
        begin
            word_q <= acc_q;
            acc_q  <= '0;
        end
    end

    assign word_o.word     = word_q;
    assign word_o.valid    = valid_q;
    assign word_o.last     = last_q;
    assign word_o.byte_cnt = cnt_q;

endmodule

// ==== verilog/rx_frame_builder.sv ====
// frame builder, reserves FIFO space and writes header, payload and trailer
`timescale 1ns/10ps

module rx_frame_builder (
    input  logic          clk,
    input  logic          rst_i,
    input  logic          hdr_strobe_i,
    input  logic          hdr_valid_i,
    input  rx_pkg::rate_t pkt_rate_i,
    input  rx_pkg::len_t  pkt_len_i,
    input  logic          fcs_ok_i,
    rx_word_if.sink       word_i,
    rx_fifo_wr_if.source  fifo_o
);

    rx_pkg::builder_state_t state_q;
    rx_pkg::sn_t            sn_q;
    logic                   ctl_wen_q;
    rx_pkg::word_t          ctl_word_q;
    rx_pkg::word_t          hdr_word;
    rx_pkg::word_t          trl_word;
    logic [16:0]            need_words;
    logic                   hdr_accept;
    logic                   fits;
    logic                   pay_wen;

    assign hdr_accept = hdr_strobe_i & hdr_valid_i;

    // payload words rounded up, plus header and trailer
    assign need_words = (17'(pkt_len_i) + 17'(rx_pkg::BYTES_PER_WORD - 1))
                        / 17'(rx_pkg::BYTES_PER_WORD)
                        + 17'(rx_pkg::FRAME_OVERHEAD);
    assign fits       = (17'(fifo_o.free_cnt) >= need_words);

    always_comb
    begin
        hdr_word = '0;
        hdr_word[rx_pkg::HDR_LEN_LSB +: $bits(rx_pkg::len_t)]   = pkt_len_i;
        hdr_word[rx_pkg::HDR_RATE_LSB +: $bits(rx_pkg::rate_t)] = pkt_rate_i;
        hdr_word[rx_pkg::HDR_SN_LSB +: $bits(rx_pkg::sn_t)]     = sn_q;
        trl_word = '0;
        trl_word[rx_pkg::TRL_FCS_BIT]                           = fcs_ok_i;
        trl_word[rx_pkg::TRL_CNT_LSB +: $bits(rx_pkg::len_t)]   = word_i.byte_cnt;
    end

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            state_q   <= rx_pkg::ST_IDLE;
            sn_q      <= '0;
            ctl_wen_q <= 1'b0;
        end
        else
        begin
            ctl_wen_q <= 1'b0;
            case (state_q)
                rx_pkg::ST_IDLE:
                begin
                    // a dropped packet still uses up its sequence number
                    if (hdr_accept)
                    begin
                        sn_q <= sn_q + 1'b1;
                        if (fits)
                        begin
                            ctl_wen_q <= 1'b1;
                            state_q   <= rx_pkg::ST_PAYLOAD;
                        end
                        else
                            state_q <= rx_pkg::ST_DISCARD;
                    end
                end
                rx_pkg::ST_PAYLOAD:
                begin
                    if (word_i.last)
                    begin
                        ctl_wen_q <= 1'b1;
                        state_q   <= rx_pkg::ST_TRAILER;
                    end
                end
                rx_pkg::ST_TRAILER:
                    state_q <= rx_pkg::ST_IDLE;
                default:
                begin
                    if (word_i.last)
                        state_q <= rx_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // header captured while idle, trailer captured at the end beat
    always_ff @(posedge clk)
    begin
        if (state_q == rx_pkg::ST_IDLE)
            ctl_word_q <= hdr_word;
        else if (state_q == rx_pkg::ST_PAYLOAD && word_i.last)
            ctl_word_q <= trl_word;
    end

    assign pay_wen      = (state_q == rx_pkg::ST_PAYLOAD) & word_i.valid;
    assign fifo_o.wen   = ctl_wen_q | pay_wen;
    assign fifo_o.wdata = pay_wen ? word_i.word : ctl_word_q;
    assign fifo_o.wlast = (state_q == rx_pkg::ST_TRAILER);

endmodule

// ==== verilog/rx_dma_fifo.sv ====
// DMA FIFO, buffers frame words and drives the AXI-stream master output
`timescale 1ns/10ps

module rx_dma_fifo (
    input  logic          clk,
    input  logic          rst_i,
    rx_fifo_wr_if.sink    fifo_i,
    output rx_pkg::word_t m_axis_tdata_o,
    output logic          m_axis_tvalid_o,
    output logic          m_axis_tlast_o,
    input  logic          m_axis_tready_i,
    output logic          rx_pkt_intr_o
);

    rx_pkg::word_t mem_data [rx_pkg::FIFO_DEPTH];
    logic          mem_last [rx_pkg::FIFO_DEPTH];
    rx_pkg::ptr_t  wr_ptr_q;
    rx_pkg::ptr_t  rd_ptr_q;
    rx_pkg::cnt_t  count_q;
    logic          rd_en;
    logic          intr_q;

    // storage, pointers wrap at the power of two depth
    always_ff @(posedge clk)
    begin
        if (fifo_i.wen)
        begin
            mem_data[wr_ptr_q] <= fifo_i.wdata;
            mem_last[wr_ptr_q] <= fifo_i.wlast;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            intr_q   <= 1'b0;
        end
        else
        begin
            if (fifo_i.wen)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (rd_en)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            count_q <= count_q + rx_pkg::cnt_t'(fifo_i.wen) - rx_pkg::cnt_t'(rd_en);
            // one pulse per frame leaving on the stream
            intr_q  <= rd_en & m_axis_tlast_o;
        end
    end

    assign fifo_i.free_cnt = rx_pkg::cnt_t'(rx_pkg::FIFO_DEPTH) - count_q;

    // head word held in place until the handshake
    assign m_axis_tvalid_o = (count_q != '0);
    assign m_axis_tdata_o  = mem_data[rd_ptr_q];
    assign m_axis_tlast_o  = m_axis_tvalid_o & mem_last[rd_ptr_q];
    assign rd_en           = m_axis_tvalid_o & m_axis_tready_i;
    assign rx_pkt_intr_o   = intr_q;

endmodule

// ==== verilog/rx_intf.sv ====
// receive interface top, decoded bytes in and framed AXI-stream words out
`timescale 1ns/10ps

module rx_intf (
    input  logic          clk,
    input  logic          rst_i,
    input  logic          pkt_header_valid_i,
    input  logic          pkt_header_valid_strobe_i,
    input  rx_pkg::rate_t pkt_rate_i,
    input  rx_pkg::len_t  pkt_len_i,
    input  rx_pkg::byte_t byte_in_i,
    input  logic          byte_in_strobe_i,
    input  logic          fcs_in_strobe_i,
    input  logic          fcs_ok_i,
    output rx_pkg::word_t m_axis_tdata_o,
    output logic          m_axis_tvalid_o,
    output logic          m_axis_tlast_o,
    input  logic          m_axis_tready_i,
    output logic          rx_pkt_intr_o
);

    rx_word_if    word_bus ();
    rx_fifo_wr_if fifo_bus ();

    rx_byte_packer u_packer (
        .clk              (clk),
        .rst_i            (rst_i),
        .hdr_strobe_i     (pkt_header_valid_strobe_i),
        .byte_in_i        (byte_in_i),
        .byte_in_strobe_i (byte_in_strobe_i),
        .fcs_in_strobe_i  (fcs_in_strobe_i),
        .word_o           (word_bus.source)
    );

    rx_frame_builder u_builder (
        .clk          (clk),
        .rst_i        (rst_i),
        .hdr_strobe_i (pkt_header_valid_strobe_i),
        .hdr_valid_i  (pkt_header_valid_i),
        .pkt_rate_i   (pkt_rate_i),
        .pkt_len_i    (pkt_len_i),
        .fcs_ok_i     (fcs_ok_i),
        .word_i       (word_bus.sink),
        .fifo_o       (fifo_bus.source)
    );

    rx_dma_fifo u_fifo (
        .clk             (clk),
        .rst_i           (rst_i),
        .fifo_i          (fifo_bus.sink),
        .m_axis_tdata_o  (m_axis_tdata_o),
        .m_axis_tvalid_o (m_axis_tvalid_o),
        .m_axis_tlast_o  (m_axis_tlast_o),
        .m_axis_tready_i (m_axis_tready_i),
        .rx_pkt_intr_o   (rx_pkt_intr_o)
    );

endmodule

// ==== sim/rx_intf_props.sv ====
// stream output assertions for the receive interface, bound onto the top level
`timescale 1ns/10ps

module rx_intf_props (
    input logic          clk,
    input logic          rst_i,
    input rx_pkg::word_t tdata_i,
    input logic          tvalid_i,
    input logic          tlast_i,
    input logic          tready_i,
    input logic          intr_i
);

    // stalled word stays put until accepted
    a_hold_while_stalled: assert property (@(posedge clk) disable iff (rst_i)
        tvalid_i && !tready_i |=> tvalid_i && $stable(tdata_i) && $stable(tlast_i))
    else $error("stream output changed while tready was low");

    a_intr_after_last: assert property (@(posedge clk) disable iff (rst_i)
        intr_i |-> $past(tvalid_i && tready_i && tlast_i))
    else $error("interrupt without an accepted tlast word one cycle earlier");

    a_idle_after_reset: assert property (@(posedge clk)
        rst_i |=> !tvalid_i && !intr_i)
    else $error("tvalid or interrupt high right after reset");

endmodule

bind rx_intf rx_intf_props u_props (
    .clk      (clk),
    .rst_i    (rst_i),
    .tdata_i  (m_axis_tdata_o),
    .tvalid_i (m_axis_tvalid_o),
    .tlast_i  (m_axis_tlast_o),
    .tready_i (m_axis_tready_i),
    .intr_i   (rx_pkt_intr_o)
);

// ==== sim/tb_rx_intf.sv ====
// testbench for the receive interface with random packets against a frame model
`timescale 1ns/10ps

module tb_rx_intf;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_PKTS     = 60;
    localparam int PH_HEADER    = 0;
    localparam int PH_PAYLOAD   = 1;
    localparam int PH_TRAILER   = 2;

    logic          clk;
    logic          rst;
    logic          hdr_valid;
    logic          hdr_strobe;
    rx_pkg::rate_t pkt_rate;
    rx_pkg::len_t  pkt_len;
    rx_pkg::byte_t byte_in;
    logic          byte_strobe;
    logic          fcs_strobe;
    logic          fcs_ok;
    rx_pkg::word_t tdata;
    logic          tvalid;
    logic          tlast;
    logic          tready;
    logic          pkt_intr;

    // model of every valid packet by sequence number
    int            exp_len [int];
    rx_pkg::rate_t exp_rate [int];
    logic          exp_fcs [int];
    int            exp_off [int];
    rx_pkg::byte_t byte_store [$];
    // sequence numbers of the frames that fit into the FIFO
    int            frame_sn [$];

    integer seed;
    int     next_sn;
    int     last_sn;
    int     phase;
    int     word_pos;
    int     words_left;
    int     words_in;
    int     words_out;
    int     frames_done;
    int     dropped;
    int     intr_cnt;
    int     rdy_hold;
    logic   draining;

    rx_intf u_dut (
        .clk                       (clk),
        .rst_i                     (rst),
        .pkt_header_valid_i        (hdr_valid),
        .pkt_header_valid_strobe_i (hdr_strobe),
        .pkt_rate_i                (pkt_rate),
        .pkt_len_i                 (pkt_len),
        .byte_in_i                 (byte_in),
        .byte_in_strobe_i          (byte_strobe),
        .fcs_in_strobe_i           (fcs_strobe),
        .fcs_ok_i                  (fcs_ok),
        .m_axis_tdata_o            (tdata),
        .m_axis_tvalid_o           (tvalid),
        .m_axis_tlast_o            (tlast),
        .m_axis_tready_i           (tready),
        .rx_pkt_intr_o             (pkt_intr)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // generous budget per packet on top of reset
    initial
    begin
        #(CLK_PERIOD * (RESET_CYCLES + 200 * NUM_PKTS));
        fail_run("watchdog expired before all frames left the FIFO");
    end

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected)
        begin
            $display("** Error: %s, expected %h, actual %h", name, expected, actual);
            fail_run("output value mismatch");
        end
    endtask

    // stalls are long enough to fill the FIFO
    task automatic pick_ready();
        if (rdy_hold != 0)
            rdy_hold = rdy_hold - 1;
        else if (rand_below(48) == 0)
        begin
            tready   <= 1'b0;
            rdy_hold = 100 + rand_below(256);
        end
        else
        begin
            tready   <= (rand_below(2) != 0);
            rdy_hold = rand_below(4);
        end
    endtask

    // strobes last one cycle unless driven again after this
    task automatic next_cycle();
        @(posedge clk);
        hdr_strobe  <= 1'b0;
        byte_strobe <= 1'b0;
        fcs_strobe  <= 1'b0;
        if (!draining)
            pick_ready();
    endtask

    task automatic send_packet(input logic hv);
        int            len;
        int            gap;
        int            k;
        int            need;
        rx_pkg::rate_t rate;
        logic          ok;
        rx_pkg::byte_t b;
        len  = 1 + rand_below(100);
        rate = 8'(rand_below(256));
        ok   = (rand_below(2) != 0);
        next_cycle();
        hdr_strobe <= 1'b1;
        hdr_valid  <= hv;
        pkt_rate   <= rate;
        pkt_len    <= 16'(len);
        if (hv)
        begin
            exp_len[next_sn]  = len;
            exp_rate[next_sn] = rate;
            exp_fcs[next_sn]  = ok;
            exp_off[next_sn]  = byte_store.size();
            // whole frame reserved at the header or the packet is dropped
            need = (len + 7) / 8 + 2;
            if (need <= rx_pkg::FIFO_DEPTH - (words_in - words_out))
            begin
                words_in = words_in + need;
                frame_sn.push_back(next_sn);
            end
            else
                dropped = dropped + 1;
            next_sn = next_sn + 1;
        end
        for (k = 0; k < len; k++)
        begin
            b = 8'(rand_below(256));
            if (hv)
                byte_store.push_back(b);
            gap = (rand_below(4) == 0) ? rand_below(3) : 0;
            repeat (gap) next_cycle();
            next_cycle();
            byte_strobe <= 1'b1;
            byte_in     <= b;
        end
        repeat (rand_below(3)) next_cycle();
        next_cycle();
        fcs_strobe <= 1'b1;
        fcs_ok     <= ok;
        // next header comes at least three cycles after the FCS strobe
        repeat (2 + rand_below(3)) next_cycle();
    endtask

    task automatic take_word();
        int          sn;
        int          lane;
        int          idx;
        logic [63:0] exp_word;
        exp_word = '0;
        if (phase == PH_HEADER)
        begin
            if (frame_sn.size() == 0)
                fail_run("header word arrived while no frame was expected");
            else
            begin
                sn                 = frame_sn.pop_front();
                last_sn            = sn;
                exp_word[15:0]     = 16'(exp_len[sn]);
                exp_word[23:16]    = exp_rate[sn];
                exp_word[47:32]    = 16'(sn);
                check_value("header word", exp_word, tdata);
                check_value("header tlast", 64'(0), 64'(tlast));
                words_left = (exp_len[sn] + 7) / 8;
                word_pos   = 0;
                phase      = PH_PAYLOAD;
            end
        end
        else if (phase == PH_PAYLOAD)
        begin
            // byte k in lane k mod 8 and unused lanes stay zero
            for (lane = 0; lane < 8; lane++)
            begin
                idx = word_pos * 8 + lane;
                if (idx < exp_len[last_sn])
                    exp_word[lane*8 +: 8] = byte_store[exp_off[last_sn] + idx];
            end
            check_value($sformatf("payload word %0d of packet %0d", word_pos, last_sn),
                        exp_word, tdata);
            check_value("payload tlast", 64'(0), 64'(tlast));
            word_pos = word_pos + 1;
            if (word_pos == words_left)
                phase = PH_TRAILER;
        end
        else
        begin
            exp_word[0]     = exp_fcs[last_sn];
            exp_word[31:16] = 16'(exp_len[last_sn]);
            check_value("trailer word", exp_word, tdata);
            check_value("trailer tlast", 64'(1), 64'(tlast));
            frames_done = frames_done + 1;
            phase       = PH_HEADER;
        end
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (pkt_intr)
                intr_cnt = intr_cnt + 1;
            if (tvalid && tready)
            begin
                words_out = words_out + 1;
                take_word();
            end
        end
    end

    initial
    begin
        int pkt;
        seed        = 32'h6c73;
        rst         = 1'b1;
        hdr_valid   = 1'b0;
        hdr_strobe  = 1'b0;
        pkt_rate    = '0;
        pkt_len     = '0;
        byte_in     = '0;
        byte_strobe = 1'b0;
        fcs_strobe  = 1'b0;
        fcs_ok      = 1'b0;
        tready      = 1'b0;
        next_sn     = 0;
        last_sn     = -1;
        phase       = PH_HEADER;
        word_pos    = 0;
        words_left  = 0;
        words_in    = 0;
        words_out   = 0;
        frames_done = 0;
        dropped     = 0;
        intr_cnt    = 0;
        rdy_hold    = 0;
        draining    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        // roughly one header in eight is invalid
        for (pkt = 0; pkt < NUM_PKTS; pkt++)
            send_packet(rand_below(8) != 0);
        draining = 1'b1;
        tready <= 1'b1;
        repeat (4) next_cycle();
        @(negedge clk);
        while (tvalid)
            @(negedge clk);
        repeat (3) @(negedge clk);
        check_value("tvalid after drain", 64'(0), 64'(tvalid));
        check_value("frame phase after drain", 64'(PH_HEADER), 64'(phase));
        check_value("frames still expected", 64'(0), 64'(frame_sn.size()));
        check_value("interrupt count", 64'(frames_done), 64'(intr_cnt));
        if (frames_done == 0)
            fail_run("no frame reached the stream output");
        else
        begin
            $display("%0d frames received, %0d packets dropped", frames_done, dropped);
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// ==== tb.f ====
verilog/rx_pkg.sv
verilog/rx_word_if.sv
verilog/rx_fifo_wr_if.sv
verilog/rx_byte_packer.sv
verilog/rx_frame_builder.sv
verilog/rx_dma_fifo.sv
verilog/rx_intf.sv
sim/rx_intf_props.sv
sim/tb_rx_intf.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_rx_intf
FILELIST  := tb.f
FLAGS     := --timing --assert
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := SIMULATION PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
